// File: field_pkg.sv
// Prime field modulus, Fp and Fp2 element types, and modular add, subtract, negate, multiply.
package field_pkg;

  parameter int FE_BITS = 16; // Width of one Fp element.
  parameter int unsigned P = 65521; // Largest prime below 2^16.

  typedef logic [FE_BITS-1:0] fe_t; // One element of Fp, always kept below P.

  // An Fp2 element is c0 + c1*u, with c1 in the upper half of the packed word.
  typedef struct packed {
    fe_t c1;
    fe_t c0;
  } fe2_t;

  // Modular addition; the sum of two reduced values is below 2P, so one subtract suffices.
  function automatic fe_t fe_add(input fe_t a, input fe_t b);
    logic [FE_BITS:0] sum;
    sum = a + b; // One extra bit holds the carry.
    if (sum >= P) sum = sum - P[FE_BITS:0];
    return sum[FE_BITS-1:0];
  endfunction

  // Modular subtraction, wrapping through P when b is larger than a.
  function automatic fe_t fe_sub(input fe_t a, input fe_t b);
    logic [FE_BITS:0] dif;
    if (a >= b) dif = a - b;
    else dif = a + P[FE_BITS:0] - b; // Borrow from the modulus.
    return dif[FE_BITS-1:0];
  endfunction

  // Additive inverse. Zero maps to zero so the result stays reduced.
  function automatic fe_t fe_neg(input fe_t a);
    return (a == '0) ? '0 : fe_t'(P - a);
  endfunction

  // Full product followed by reduction with the remainder operator.
  function automatic fe_t fe_mul(input fe_t a, input fe_t b);
    logic [2*FE_BITS-1:0] prod;
    prod = a * b; // Double width product, no truncation.
    return fe_t'(prod % P);
  endfunction

endpackage

// File: fmap_pkg.sv
// Frobenius control word layout, power type, and the Fp6 coefficient tables for powers 0 to 3.
package fmap_pkg;

  // Default width of the control word that travels beside every data beat.
  parameter int CTL_BITS = 12;

  // Lowest bit of the 2-bit power field inside the control word.
  parameter int CTL_BIT_POW = 8;

  // Frobenius power, only 0 to 3 are supported.
  typedef logic [1:0] pow_t;

  // Coefficients applied to part c1 of the Fp6 element, indexed by power.
  // Entry 0 is one, so power 0 leaves the element unchanged.
  // The odd powers have a purely imaginary coefficient, as in the
  // pairing-friendly towers that this reduced field stands in for.
  parameter field_pkg::fe2_t FROB_C1 [4] = '{
    '{c1: 16'd0,     c0: 16'd1},     // Power 0.
    '{c1: 16'd14089, c0: 16'd0},     // Power 1.
    '{c1: 16'd0,     c0: 16'd37813}, // Power 2.
    '{c1: 16'd1,     c0: 16'd0}      // Power 3.
  };

  // Coefficients applied to part c2 of the Fp6 element, indexed by power.
  // All of these are real, so only the c0 half is ever non-zero.
  // Power 3 multiplies by minus one.
  parameter field_pkg::fe2_t FROB_C2 [4] = '{
    '{c1: 16'd0, c0: 16'd1},     // Power 0.
    '{c1: 16'd0, c0: 16'd37814}, // Power 1.
    '{c1: 16'd0, c0: 16'd27707}, // Power 2.
    '{c1: 16'd0, c0: 16'd65520}  // Power 3.
  };

  // The power field is read from the control word with this slice:
  //   ctl[CTL_BIT_POW +: 2]
  // Bits outside the field are opaque user bits and pass through unchanged.
  // Every module that touches the control word takes the width and the
  // field position as parameters, so a wider word can be used at the top.

endpackage

// File: fe2_fmap.sv
// Registered Fp2 Frobenius stage that conjugates each Fp2 pair for odd powers.
`timescale 1ns/1ps

module fe2_fmap #(
  parameter int CTL_BITS    = fmap_pkg::CTL_BITS,
  parameter int CTL_BIT_POW = fmap_pkg::CTL_BIT_POW
) (
  input  logic                i_clk,
  input  logic                i_rst,
  input  logic                i_val,
  input  field_pkg::fe_t      i_dat,
  input  logic [CTL_BITS-1:0] i_ctl,
  input  logic                i_o_rdy,
  output logic                o_rdy,
  output logic                o_val,
  output field_pkg::fe_t      o_dat,
  output logic                o_sop,
  output logic                o_eop,
  output logic [CTL_BITS-1:0] o_ctl
);

  fmap_pkg::pow_t pow; // Power field of the beat on the input.
  logic           odd_beat; // High when the input beat is the c1 half of a pair.
  logic           conj; // Negate this beat.

  assign pow      = i_ctl[CTL_BIT_POW +: 2];
  assign odd_beat = o_sop; // The sop toggle is set right after an even beat.
  assign conj     = odd_beat & pow[0]; // Conjugation only for powers 1 and 3.

  // The output register can take a beat when empty or draining this cycle.
  assign o_rdy = ~o_val | i_o_rdy;

  // Valid and framing. The sop flag doubles as the beat parity toggle.
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_val <= 1'b0;
      o_sop <= 1'b0;
      o_eop <= 1'b0;
    end else if (o_rdy) begin
      o_val <= i_val;
      if (i_val) begin
        o_sop <= ~o_sop; // Set on c0, cleared on c1.
        o_eop <= o_sop; // The c1 beat closes the pair.
      end
    end
  end

  // Payload follows every accepted beat.
  always_ff @(posedge i_clk) begin
    if (o_rdy && i_val) begin
      o_dat <= conj ? field_pkg::fe_neg(i_dat) : i_dat;
      o_ctl <= i_ctl;
    end
  end

endmodule

// File: fe2_mul.sv
// Streaming Fp2 multiplier taking two operand beats and returning two product beats.
`timescale 1ns/1ps

module fe2_mul #(
  parameter int CTL_BITS = fmap_pkg::CTL_BITS
) (
  input  logic                      i_clk,
  input  logic                      i_rst,
  input  logic                      i_val,
  input  field_pkg::fe_t [1:0]      i_dat, // [0] is the element half, [1] the coefficient half.
  input  logic                      i_sop,
  input  logic [CTL_BITS-1:0]       i_ctl,
  input  logic                      i_o_rdy,
  output logic                      o_rdy,
  output logic                      o_val,
  output field_pkg::fe_t            o_dat,
  output logic                      o_sop,
  output logic                      o_eop,
  output logic [CTL_BITS-1:0]       o_ctl
);

  field_pkg::fe_t a0_q; // Element c0 held from the first beat.
  field_pkg::fe_t b0_q; // Coefficient c0 held from the first beat.
  field_pkg::fe_t a1; // Element c1 on the second beat.
  field_pkg::fe_t b1; // Coefficient c1 on the second beat.
  field_pkg::fe_t c0; // Real part of the product.
  field_pkg::fe_t c1; // Imaginary part of the product.
  field_pkg::fe_t c1_q; // Imaginary part waiting behind the real part.
  logic           take; // A beat transfers on the input.
  logic           drain; // A product beat transfers on the output.

  assign a1 = i_dat[0];
  assign b1 = i_dat[1];

  // Schoolbook product with u^2 = -1.
  assign c0 = field_pkg::fe_sub(field_pkg::fe_mul(a0_q, b0_q),
                                field_pkg::fe_mul(a1, b1));
  assign c1 = field_pkg::fe_add(field_pkg::fe_mul(a0_q, b1),
                                field_pkg::fe_mul(a1, b0_q));

  // The first beat only fills the hold registers, so it may enter whenever the
  // output is moving. The second beat needs the output slot itself, which is
  // free once the c1 product leaves. Ready stays low while a product is stuck.
  always_comb begin
    if (i_sop) o_rdy = ~o_val | i_o_rdy;
    else o_rdy = ~o_val | (o_eop & i_o_rdy);
  end

  assign take  = i_val & o_rdy;
  assign drain = o_val & i_o_rdy;

  // Output valid and framing. Eop marks the c1 product and also serves as
  // the phase bit of the output pair.
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_val <= 1'b0;
      o_sop <= 1'b0;
      o_eop <= 1'b0;
    end else begin
      if (drain) begin
        if (o_eop) begin
          o_val <= 1'b0; // Pair complete.
        end else begin
          o_sop <= 1'b0; // Move on to the c1 product.
          o_eop <= 1'b1;
        end
      end
      if (take && !i_sop) begin
        o_val <= 1'b1; // Second operand beat in, c0 product ready next cycle.
        o_sop <= 1'b1;
        o_eop <= 1'b0;
      end
    end
  end

  // Operand hold and product registers carry no reset.
  always_ff @(posedge i_clk) begin
    if (drain && !o_eop) o_dat <= c1_q; // Present c1 once c0 has gone.
    if (take) begin
      if (i_sop) begin
        a0_q <= i_dat[0];
        b0_q <= i_dat[1];
      end else begin
        o_dat <= c0;
        c1_q  <= c1;
        o_ctl <= i_ctl; // Control of the second beat goes with both products.
      end
    end
  end

endmodule

// File: fe6_fmap_coeffs.sv
// Combinational table that returns the Frobenius coefficient beat for a power and beat index.
`timescale 1ns/1ps

module fe6_fmap_coeffs (
  input  fmap_pkg::pow_t i_pow,
  input  logic [2:0]     i_beat,
  output field_pkg::fe_t o_coeff
);

  field_pkg::fe2_t c1_sel; // Coefficient for Fp6 part c1 at this power.
  field_pkg::fe2_t c2_sel; // Coefficient for Fp6 part c2 at this power.

  assign c1_sel = fmap_pkg::FROB_C1[i_pow];
  assign c2_sel = fmap_pkg::FROB_C2[i_pow];

  // Beats 0 and 1 are part c0 of the element, which is multiplied by one.
  // Beats 2 to 5 take the halves of the table entry, c0 half first.
  always_comb begin
    case (i_beat)
      3'd0: o_coeff = field_pkg::fe_t'(1); // Real half of one.
      3'd1: o_coeff = '0; // Imaginary half of one.
      3'd2: o_coeff = c1_sel.c0;
      3'd3: o_coeff = c1_sel.c1;
      3'd4: o_coeff = c2_sel.c0;
      3'd5: o_coeff = c2_sel.c1;
      default: o_coeff = '0; // Counters never reach 6 or 7.
    endcase
  end

endmodule

// File: fe6_fmap.sv
// Fp6 Frobenius sequencer that routes beats through the Fp2 stages and frames the result.
`timescale 1ns/1ps

module fe6_fmap #(
  parameter int CTL_BITS    = fmap_pkg::CTL_BITS,
  parameter int CTL_BIT_POW = fmap_pkg::CTL_BIT_POW
) (
  input  logic                 i_clk,
  input  logic                 i_rst,
  // Top level stream, one Fp beat per transfer.
  input  logic                 i_val,
  input  field_pkg::fe_t       i_dat,
  input  logic [CTL_BITS-1:0]  i_ctl,
  output logic                 o_rdy,
  output logic                 o_val,
  output field_pkg::fe_t       o_dat,
  output logic                 o_sop,
  output logic                 o_eop,
  output logic [CTL_BITS-1:0]  o_ctl,
  input  logic                 i_o_rdy,
  // Out to the Fp2 Frobenius stage and back.
  output logic                 o_f2_val,
  output field_pkg::fe_t       o_f2_dat,
  output logic [CTL_BITS-1:0]  o_f2_ctl,
  input  logic                 i_f2_rdy,
  input  logic                 i_f2r_val,
  input  field_pkg::fe_t       i_f2r_dat,
  input  logic [CTL_BITS-1:0]  i_f2r_ctl,
  output logic                 o_f2r_rdy,
  // Out to the Fp2 multiplier and back, two Fp values per outgoing beat.
  output logic                 o_mul_val,
  output field_pkg::fe_t [1:0] o_mul_dat,
  output logic                 o_mul_sop,
  output logic [CTL_BITS-1:0]  o_mul_ctl,
  input  logic                 i_mul_rdy,
  input  logic                 i_mulr_val,
  input  field_pkg::fe_t       i_mulr_dat,
  input  logic [CTL_BITS-1:0]  i_mulr_ctl,
  output logic                 o_mulr_rdy,
  // Coefficient lookup, answered in the same cycle.
  output fmap_pkg::pow_t       o_pow,
  output logic [2:0]           o_beat,
  input  field_pkg::fe_t       i_coeff
);

  logic [2:0] mul_cnt; // Beat index of the next beat towards the multiplier.
  logic [2:0] out_cnt; // Beat index of the next beat on the top output.
  logic       f2r_take; // A mapped beat enters the multiplier path register.
  logic       mulr_take; // A product beat enters the output register.

  // Each path register accepts when empty or when it empties this cycle.
  assign o_rdy      = ~o_f2_val | i_f2_rdy;
  assign o_f2r_rdy  = ~o_mul_val | i_mul_rdy;
  assign o_mulr_rdy = ~o_val | i_o_rdy;

  assign f2r_take  = i_f2r_val & o_f2r_rdy;
  assign mulr_take = i_mulr_val & o_mulr_rdy;

  // The coefficient is looked up for the mapped beat now at the input.
  assign o_pow  = i_f2r_ctl[CTL_BIT_POW +: 2];
  assign o_beat = mul_cnt;

  // Valids, counters and framing.
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_f2_val  <= 1'b0;
      o_mul_val <= 1'b0;
      o_mul_sop <= 1'b0;
      o_val     <= 1'b0;
      o_sop     <= 1'b0;
      o_eop     <= 1'b0;
      mul_cnt   <= '0;
      out_cnt   <= '0;
    end else begin
      if (o_rdy) o_f2_val <= i_val;
      if (o_f2r_rdy) begin
        o_mul_val <= i_f2r_val;
        if (i_f2r_val) begin
          o_mul_sop <= ~mul_cnt[0]; // Even beats open an Fp2 pair.
          mul_cnt   <= (mul_cnt == 3'd5) ? 3'd0 : mul_cnt + 3'd1;
        end
      end
      if (o_mulr_rdy) begin
        o_val <= i_mulr_val;
        if (i_mulr_val) begin
          o_sop   <= (out_cnt == 3'd0);
          o_eop   <= (out_cnt == 3'd5);
          out_cnt <= (out_cnt == 3'd5) ? 3'd0 : out_cnt + 3'd1;
        end
      end
    end
  end

  // Payload registers of the three paths.
  always_ff @(posedge i_clk) begin
    if (o_rdy && i_val) begin
      o_f2_dat <= i_dat;
      o_f2_ctl <= i_ctl;
    end
    if (f2r_take) begin
      o_mul_dat <= {i_coeff, i_f2r_dat}; // Coefficient high, element low.
      o_mul_ctl <= i_f2r_ctl;
    end
    if (mulr_take) begin
      o_dat <= i_mulr_dat;
      o_ctl <= i_mulr_ctl;
    end
  end

endmodule

// File: fe6_fmap_top.sv
// Top level wiring the Fp6 sequencer to its coefficient table and the two Fp2 stages.
`timescale 1ns/1ps

module fe6_fmap_top #(
  parameter int CTL_BITS    = fmap_pkg::CTL_BITS,
  parameter int CTL_BIT_POW = fmap_pkg::CTL_BIT_POW
) (
  input  logic                i_clk,
  input  logic                i_rst,
  input  logic                i_val,
  input  field_pkg::fe_t      i_dat,
  input  logic [CTL_BITS-1:0] i_ctl,
  output logic                o_rdy,
  output logic                o_val,
  output field_pkg::fe_t      o_dat,
  output logic                o_sop,
  output logic                o_eop,
  output logic [CTL_BITS-1:0] o_ctl,
  input  logic                i_o_rdy
);

  // Sequencer to Fp2 Frobenius and back.
  logic                 f2_val;
  field_pkg::fe_t       f2_dat;
  logic [CTL_BITS-1:0]  f2_ctl;
  logic                 f2_rdy;
  logic                 f2r_val;
  field_pkg::fe_t       f2r_dat;
  logic [CTL_BITS-1:0]  f2r_ctl;
  logic                 f2r_rdy;
  // Sequencer to Fp2 multiplier and back.
  logic                 mul_val;
  field_pkg::fe_t [1:0] mul_dat;
  logic                 mul_sop;
  logic [CTL_BITS-1:0]  mul_ctl;
  logic                 mul_rdy;
  logic                 mulr_val;
  field_pkg::fe_t       mulr_dat;
  logic [CTL_BITS-1:0]  mulr_ctl;
  logic                 mulr_rdy;
  // Coefficient lookup.
  fmap_pkg::pow_t       pow;
  logic [2:0]           beat;
  field_pkg::fe_t       coeff;

  fe6_fmap #(.CTL_BITS(CTL_BITS), .CTL_BIT_POW(CTL_BIT_POW)) u_fe6_fmap (
    .i_clk, .i_rst, .i_val, .i_dat, .i_ctl, .o_rdy,
    .o_val, .o_dat, .o_sop, .o_eop, .o_ctl, .i_o_rdy,
    .o_f2_val(f2_val), .o_f2_dat(f2_dat), .o_f2_ctl(f2_ctl), .i_f2_rdy(f2_rdy),
    .i_f2r_val(f2r_val), .i_f2r_dat(f2r_dat), .i_f2r_ctl(f2r_ctl), .o_f2r_rdy(f2r_rdy),
    .o_mul_val(mul_val), .o_mul_dat(mul_dat), .o_mul_sop(mul_sop), .o_mul_ctl(mul_ctl),
    .i_mul_rdy(mul_rdy), .i_mulr_val(mulr_val), .i_mulr_dat(mulr_dat),
    .i_mulr_ctl(mulr_ctl), .o_mulr_rdy(mulr_rdy),
    .o_pow(pow), .o_beat(beat), .i_coeff(coeff)
  );

  fe6_fmap_coeffs u_coeffs (.i_pow(pow), .i_beat(beat), .o_coeff(coeff));

  // Framing of the Fp2 stages is local to them, the sequencer keeps its own counts.
  fe2_fmap #(.CTL_BITS(CTL_BITS), .CTL_BIT_POW(CTL_BIT_POW)) u_fe2_fmap (
    .i_clk, .i_rst, .i_val(f2_val), .i_dat(f2_dat), .i_ctl(f2_ctl), .i_o_rdy(f2r_rdy),
    .o_rdy(f2_rdy), .o_val(f2r_val), .o_dat(f2r_dat), .o_sop(), .o_eop(), .o_ctl(f2r_ctl)
  );

  fe2_mul #(.CTL_BITS(CTL_BITS)) u_fe2_mul (
    .i_clk, .i_rst, .i_val(mul_val), .i_dat(mul_dat), .i_sop(mul_sop), .i_ctl(mul_ctl),
    .i_o_rdy(mulr_rdy), .o_rdy(mul_rdy), .o_val(mulr_val), .o_dat(mulr_dat),
    .o_sop(), .o_eop(), .o_ctl(mulr_ctl)
  );

endmodule

// File: fe6_fmap_checker.sv
// Assertions on the top output stream of the Frobenius map, and their bind to the top level.
`timescale 1ns/1ps

module fe6_fmap_checker #(
  parameter int CTL_BITS = fmap_pkg::CTL_BITS
) (
  input logic                i_clk,
  input logic                i_rst,
  input logic                i_out_val,
  input logic                i_out_rdy,
  input field_pkg::fe_t      i_out_dat,
  input logic                i_out_sop,
  input logic                i_out_eop,
  input logic [CTL_BITS-1:0] i_out_ctl
);

  int assert_errs = 0; // Failures seen, read by the testbench summary.

  // A stalled beat may not be withdrawn.
  a_val_hold: assert property (@(posedge i_clk) disable iff (i_rst)
    i_out_val && !i_out_rdy |=> i_out_val)
    else begin
      $error("Output valid dropped while the beat was stalled.");
      assert_errs++;
    end

  // Payload and framing hold still until the transfer.
  a_stable: assert property (@(posedge i_clk) disable iff (i_rst)
    i_out_val && !i_out_rdy |=> $stable(i_out_dat) && $stable(i_out_sop) &&
                                $stable(i_out_eop) && $stable(i_out_ctl))
    else begin
      $error("Output beat changed while stalled.");
      assert_errs++;
    end

  // A frame is six beats long, so its first and last beat differ.
  a_sop_eop: assert property (@(posedge i_clk) disable iff (i_rst)
    i_out_val |-> !(i_out_sop && i_out_eop))
    else begin
      $error("Output sop and eop on the same beat.");
      assert_errs++;
    end

endmodule

bind fe6_fmap_top fe6_fmap_checker #(.CTL_BITS(CTL_BITS)) chk_i (
  .i_clk(i_clk), .i_rst(i_rst), .i_out_val(o_val), .i_out_rdy(i_o_rdy),
  .i_out_dat(o_dat), .i_out_sop(o_sop), .i_out_eop(o_eop), .i_out_ctl(o_ctl)
);

// File: tb_fe6_fmap.sv
// Testbench for the Fp6 Frobenius map: clock, stimulus, reference model, compare tasks and summary.
`timescale 1ns/1ps

module tb_fe6_fmap;

  localparam int CTL_BITS    = fmap_pkg::CTL_BITS;
  localparam int CTL_BIT_POW = fmap_pkg::CTL_BIT_POW;
  localparam longint PL      = field_pkg::P; // Signed copy of the modulus for the model.
  localparam int N_ELEMS     = 4 + 6 + 200 + 100; // Elements over all four tests.
  localparam int MAX_CYCLES  = 60 * N_ELEMS + 500;

  typedef field_pkg::fe_t [5:0] fe6_t; // Beat 0 (c0.c0) sits in slot 0.
  typedef logic [CTL_BITS-1:0] ctl_t;

  logic           i_clk = 1'b0;
  logic           i_rst = 1'b1;
  logic           i_val = 1'b0;
  field_pkg::fe_t i_dat = '0;
  ctl_t           i_ctl = '0;
  logic           i_o_rdy = 1'b1;
  logic           o_rdy;
  logic           o_val;
  field_pkg::fe_t o_dat;
  logic           o_sop;
  logic           o_eop;
  ctl_t           o_ctl;

  fe6_t exp_q[$]; // Expected results, oldest first.
  ctl_t exp_ctl_q[$];
  fe6_t got; // Beats of the frame being collected.
  ctl_t got_ctl [6];
  int   beat_idx = 0;
  int   val_errs = 0;
  int   frame_errs = 0;
  int   n_sent = 0;
  int   n_done = 0;
  int   cycles = 0;
  int   seed;
  logic bp_on = 1'b0; // Random back-pressure on the output when set.
  logic first_acc = 1'b0; // First input beat has been accepted.
  logic rdy_pat [1024]; // Output ready pattern, drawn after seeding.

  fe6_fmap_top #(.CTL_BITS(CTL_BITS), .CTL_BIT_POW(CTL_BIT_POW)) dut_i (.*);

  always #10 i_clk = ~i_clk;

  // Conjugate each Fp2 part for odd powers, then multiply parts 1 and 2 by the
  // table coefficients, with u^2 = -1.
  function automatic fe6_t ref_fe6_fmap(input fe6_t x, input fmap_pkg::pow_t pow);
    fe6_t            y;
    field_pkg::fe2_t k;
    longint          k0; // Real half of the coefficient as a signed number.
    longint          k1; // Imaginary half of the coefficient as a signed number.
    longint          a0;
    longint          a1;
    longint          re;
    longint          im;
    for (int part = 0; part < 3; part++) begin
      a0 = x[2*part];
      a1 = x[2*part+1];
      if (pow[0]) a1 = (PL - a1) % PL; // Conjugation negates the imaginary half.
      k.c0 = 16'd1;
      k.c1 = 16'd0;
      if (part == 1) k = fmap_pkg::FROB_C1[pow];
      if (part == 2) k = fmap_pkg::FROB_C2[pow];
      k0 = k.c0;
      k1 = k.c1;
      re = (a0 * k0 - a1 * k1) % PL;
      if (re < 0) re = re + PL; // Bring the signed remainder back into range.
      im = (a0 * k1 + a1 * k0) % PL;
      y[2*part]   = field_pkg::fe_t'(re);
      y[2*part+1] = field_pkg::fe_t'(im);
    end
    return y;
  endfunction

  task automatic cmp_fe(input field_pkg::fe_t got_v, input field_pkg::fe_t exp_v, input int beat);
    if (got_v !== exp_v) begin
      $display("ERR %0t: element %0d beat %0d data %0d, expected %0d",
               $time, n_done, beat, got_v, exp_v);
      val_errs++;
    end
  endtask

  task automatic cmp_ctl(input ctl_t got_v, input ctl_t exp_v, input int beat);
    if (got_v !== exp_v) begin
      $display("ERR %0t: element %0d beat %0d ctl 0x%0h, expected 0x%0h",
               $time, n_done, beat, got_v, exp_v);
      val_errs++;
    end
  endtask

  // Store one output beat; a complete frame is compared with the oldest expected element.
  task automatic collect_beat();
    fe6_t want;
    ctl_t want_ctl;
    if (o_sop != (beat_idx == 0) || o_eop != (beat_idx == 5)) begin
      $display("Framing error at %0t: beat %0d of a frame came with sop %0b and eop %0b.",
               $time, beat_idx, o_sop, o_eop);
      frame_errs++;
    end
    got[beat_idx]     = o_dat;
    got_ctl[beat_idx] = o_ctl;
    if (beat_idx == 5) begin
      if (exp_q.size() == 0) begin
        $display("An output frame arrived at %0t with no element outstanding.", $time);
        frame_errs++;
      end else begin
        want     = exp_q.pop_front();
        want_ctl = exp_ctl_q.pop_front();
        for (int b = 0; b < 6; b++) begin
          cmp_fe(got[b], want[b], b);
          cmp_ctl(got_ctl[b], want_ctl, b);
        end
      end
      n_done++;
      beat_idx = 0;
    end else begin
      beat_idx++;
    end
  endtask

  // Sample at the falling edge, where everything driven after the rising edge has settled.
  always @(negedge i_clk) begin
    if (!i_rst) begin
      if (o_val && !first_acc) begin
        $display("Output valid went high at %0t before any input was accepted.", $time);
        frame_errs++;
      end
      if (i_val && o_rdy) first_acc = 1'b1;
      if (o_val && i_o_rdy) collect_beat(); // Transfer happens on the next rising edge.
    end
  end

  // Output ready, full throughput unless back-pressure is on.
  always @(posedge i_clk) begin
    #1;
    i_o_rdy = bp_on ? rdy_pat[cycles % 1024] : 1'b1;
  end

  // Cycle limit so that a stuck handshake cannot hang the run.
  always @(posedge i_clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout after %0d cycles with %0d of %0d elements checked.",
               cycles, n_done, n_sent);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  // Drive six beats back to back; entered and left 1 ns after a rising edge.
  task automatic send_elem(input fe6_t x, input ctl_t ctl);
    exp_q.push_back(ref_fe6_fmap(x, ctl[CTL_BIT_POW +: 2]));
    exp_ctl_q.push_back(ctl);
    n_sent++;
    for (int b = 0; b < 6; b++) begin
      i_val = 1'b1;
      i_dat = x[b];
      i_ctl = ctl; // One control word for the whole element.
      do begin
        @(negedge i_clk);
      end while (!o_rdy);
      @(posedge i_clk);
      #1;
    end
    i_val = 1'b0;
  endtask

  task automatic rand_elem(output fe6_t x);
    for (int b = 0; b < 6; b++) x[b] = field_pkg::fe_t'($urandom % field_pkg::P);
  endtask

  function automatic ctl_t rand_ctl(input fmap_pkg::pow_t pow);
    ctl_t c;
    c = ctl_t'($urandom);
    c[CTL_BIT_POW +: 2] = pow; // User bits random, power field fixed.
    return c;
  endfunction

  initial begin
    fe6_t x;
    int   total;
    seed = $urandom(56420);
    for (int i = 0; i < 1024; i++) rdy_pat[i] = ($urandom % 4) != 0; // Ready 3 cycles in 4.
    repeat (2) @(posedge i_clk);
    #1;
    i_rst = 1'b0;
    repeat (5) @(posedge i_clk); // Idle cycles, o_val must stay low.
    #1;
    for (int n = 0; n < 4; n++) begin // Power 0 is the identity.
      rand_elem(x);
      send_elem(x, rand_ctl(2'd0));
    end
    for (int p = 1; p < 4; p++) begin // Fixed elements at powers 1 to 3.
      send_elem({16'd6, 16'd5, 16'd4, 16'd3, 16'd2, 16'd1}, rand_ctl(fmap_pkg::pow_t'(p)));
      send_elem({16'd0, 16'd65520, 16'd40000, 16'd1, 16'd12345, 16'd65520},
                rand_ctl(fmap_pkg::pow_t'(p)));
    end
    for (int n = 0; n < 200; n++) begin
      rand_elem(x);
      send_elem(x, rand_ctl(fmap_pkg::pow_t'($urandom % 4)));
    end
    bp_on = 1'b1;
    for (int n = 0; n < 100; n++) begin
      rand_elem(x);
      send_elem(x, rand_ctl(fmap_pkg::pow_t'($urandom % 4)));
    end
    while (n_done < n_sent) @(posedge i_clk);
    bp_on = 1'b0;
    repeat (10) @(posedge i_clk); // Any stray beat would show up here.
    if (beat_idx != 0) begin
      $display("The run ended with %0d beats of an incomplete output frame.", beat_idx);
      frame_errs++;
    end
    total = val_errs + frame_errs + dut_i.chk_i.assert_errs;
    $display("Value errors %0d, framing errors %0d, assertion failures %0d.",
             val_errs, frame_errs, dut_i.chk_i.assert_errs);
    if (total == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// File: vlog.f
field_pkg.sv
fmap_pkg.sv
fe2_fmap.sv
fe2_mul.sv
fe6_fmap_coeffs.sv
fe6_fmap.sv
fe6_fmap_top.sv
fe6_fmap_checker.sv
tb_fe6_fmap.sv
